// File: source/fetch_settings.svh
/*
 * Build-time sizes of the instruction fetch front end:
 * address and branch number widths, cache geometry,
 * reset fetch address and warm-up length
 */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Width of a fetch address in bits
`define FETCH_PC_BITS 32

// Width of the branch number that tags each fetch path
`define FETCH_BNO_BITS 5

// Instruction words in one cache line and thus in one 16-byte fetch group
`define FETCH_LINE_WORDS 4

// Number of lines in the direct-mapped instruction cache as a power of two
`define FETCH_ICACHE_LINES 8

// First address fetched once reset is released
`define FETCH_RESET_PC 32'h0000_0100

// Cycles after reset during which the fetch stage only emits NOP lines
`define FETCH_WARMUP_CYCLES 4

`endif

// File: source/fetch_pkg.sv
/*
 * Shared types of the fetch front end: address, branch number,
 * instruction word, cache line and half line, the opcode enum
 * and the NOP instruction word
 */
`include "fetch_settings.svh"

package fetch_pkg;

	// Instruction words are always 32 bits wide
	localparam int INSTR_BITS = 32;

	// Fetch address and branch number
	typedef logic [`FETCH_PC_BITS-1:0] pc_t;
	typedef logic [`FETCH_BNO_BITS-1:0] bno_t;

	// Major opcode held in the top seven bits of every instruction word
	typedef enum logic [6:0] {
		OP_NOP    = 7'h3f,
		OP_ALU    = 7'h01,
		OP_LOAD   = 7'h02,
		OP_STORE  = 7'h03,
		OP_BRANCH = 7'h04,
		OP_JUMP   = 7'h05
	} opcode_e;

	typedef logic [INSTR_BITS-1:0] instr_t;

	// A full cache line with slot 0 in the low word
	typedef logic [`FETCH_LINE_WORDS*INSTR_BITS-1:0] line_t;

	// Half a line, as delivered by the instruction injection path
	typedef logic [`FETCH_LINE_WORDS*INSTR_BITS/2-1:0] half_line_t;

	// NOP opcode with every other field cleared
	localparam instr_t NOP_WORD = {OP_NOP, {(INSTR_BITS - $bits(opcode_e)){1'b0}}};

endpackage

// File: source/fetch_pc_sequencer.sv
/*
 * Fetch address sequencer: holds the sequential fetch address and
 * the current branch number, handles redirects, holds on a cache
 * miss and hands the address over to the micro-machine
 */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_pc_sequencer (
	input  logic             clk,
	input  logic             rst,
	input  logic             en_i,
	input  logic             stall_i,
	input  logic             hit_i,
	input  logic             redirect_i,
	input  fetch_pkg::pc_t   redirect_pc_i,
	input  logic             mc_active_i,
	input  fetch_pkg::pc_t   mc_adr_i,
	output fetch_pkg::pc_t   pc_o,
	output fetch_pkg::bno_t  bno_o
);

	// ======================================================================
	// Constants
	// ======================================================================

	// One fetch group covers a whole cache line
	localparam fetch_pkg::pc_t LINE_BYTES = fetch_pkg::pc_t'(`FETCH_LINE_WORDS * 4);

	// First path after reset carries branch number 1
	localparam fetch_pkg::bno_t FIRST_BNO = fetch_pkg::bno_t'(1);

	// ======================================================================
	// Address and branch number registers
	// ======================================================================

	fetch_pkg::pc_t  pc_q;
	fetch_pkg::bno_t bno_q;

	// High when the sequential address may step to the next line
	logic advance;

	// The group only moves on when the pipe takes it and the cache delivered it
	// Under the micro-machine the sequential address is parked
	assign advance = en_i & ~stall_i & hit_i & ~mc_active_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= `FETCH_RESET_PC;
			bno_q <= FIRST_BNO;
		end
		else if (redirect_i) begin
			// A redirect opens a new path
			// The new number lets later stomps find groups of the old path
			pc_q <= redirect_pc_i;
			bno_q <= bno_q + FIRST_BNO;
		end
		else if (advance) begin
			pc_q <= pc_q + LINE_BYTES;
		end
		// Miss, stall and micro-machine all fall through and hold the address
	end

	// ======================================================================
	// Outputs
	// ======================================================================

	// While the micro-machine runs, the cache and fetch stage see its address
	// The sequential address stays in pc_q and resumes once it releases
	assign pc_o = mc_active_i ? mc_adr_i : pc_q;

	// Branch number of the group currently being looked up
	assign bno_o = bno_q;

endmodule

// File: source/fetch_icache.sv
/*
 * Direct-mapped instruction cache: data, tag and valid arrays,
 * line fills from an external strobe and a combinational lookup
 * of the current fetch address
 */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_icache (
	input  logic              clk,
	input  logic              rst,
	input  fetch_pkg::pc_t    pc_i,
	input  logic              fill_valid_i,
	input  fetch_pkg::pc_t    fill_adr_i,
	input  fetch_pkg::line_t  fill_line_i,
	output logic              hit_o,
	output fetch_pkg::line_t  line_o
);

	// ======================================================================
	// Address split
	// ======================================================================

	// Byte offset within a 16-byte line
	localparam int OFFSET_BITS = $clog2(`FETCH_LINE_WORDS * 4);

	// Line index into the arrays
	localparam int INDEX_BITS = $clog2(`FETCH_ICACHE_LINES);

	// Everything above the index is stored as the tag
	localparam int TAG_BITS = `FETCH_PC_BITS - INDEX_BITS - OFFSET_BITS;

	logic [INDEX_BITS-1:0] rd_index;
	logic [TAG_BITS-1:0]   rd_tag;
	logic [INDEX_BITS-1:0] wr_index;
	logic [TAG_BITS-1:0]   wr_tag;

	// Lookup side follows the fetch address
	assign rd_index = pc_i[OFFSET_BITS +: INDEX_BITS];
	assign rd_tag = pc_i[OFFSET_BITS + INDEX_BITS +: TAG_BITS];

	// Fill side follows the refill address
	assign wr_index = fill_adr_i[OFFSET_BITS +: INDEX_BITS];
	assign wr_tag = fill_adr_i[OFFSET_BITS + INDEX_BITS +: TAG_BITS];

	// ======================================================================
	// Storage
	// ======================================================================

	fetch_pkg::line_t    data_mem [0:`FETCH_ICACHE_LINES-1];
	logic [TAG_BITS-1:0] tag_mem  [0:`FETCH_ICACHE_LINES-1];

	// One valid bit per line
	logic [`FETCH_ICACHE_LINES-1:0] valid_q;

	// Valid bits are the only cache state that reset touches
	// An empty cache then misses on every address
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end
		else if (fill_valid_i) begin
			valid_q[wr_index] <= 1'b1;
		end
	end

	// A fill replaces the whole line and its tag in one edge
	// The old line at that index is simply overwritten
	always_ff @(posedge clk) begin
		if (fill_valid_i) begin
			data_mem[wr_index] <= fill_line_i;
			tag_mem[wr_index] <= wr_tag;
		end
	end

	// ======================================================================
	// Lookup
	// ======================================================================

	// A fill written at an edge hits from the next cycle on because the lookup is combinational
	assign hit_o = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);

	// The line is presented whether or not it hit
	// The fetch stage swaps in NOPs on a miss
	assign line_o = data_mem[rd_index];

endmodule

// File: source/fetch_stage.sv
/*
 * Fetch pipeline register: slot addresses of the fetch group,
 * warm-up after reset, NOP fill on miss, stomp, NMI and flush,
 * half-line injection and the registered flags
 */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    en_i,
	input  logic                    stall_i,
	input  fetch_pkg::pc_t          pc_i,
	input  fetch_pkg::bno_t         bno_i,
	input  logic                    mc_active_i,
	input  logic                    hit_i,
	input  fetch_pkg::line_t        line_i,
	input  logic                    flush_i,
	input  logic                    nmi_i,
	input  logic                    stomp_i,
	input  fetch_pkg::bno_t         stomp_bno_i,
	input  logic                    inject_i,
	input  fetch_pkg::half_line_t   inj_line_i,
	output fetch_pkg::pc_t          pc0_fet_o,
	output fetch_pkg::pc_t          pc1_fet_o,
	output fetch_pkg::pc_t          pc2_fet_o,
	output fetch_pkg::pc_t          pc3_fet_o,
	output fetch_pkg::bno_t         bno_fet_o,
	output fetch_pkg::line_t        line_fet_o,
	output logic                    miss_fet_o,
	output logic                    flush_fet_o,
	output logic                    mc_active_fet_o
);

	// ======================================================================
	// Constants and control
	// ======================================================================

	localparam fetch_pkg::line_t NOP_LINE = {`FETCH_LINE_WORDS{fetch_pkg::NOP_WORD}};
	localparam fetch_pkg::half_line_t NOP_HALF = {(`FETCH_LINE_WORDS/2){fetch_pkg::NOP_WORD}};

	localparam int WARM_BITS = $clog2(`FETCH_WARMUP_CYCLES + 1);

	// The group moves into the stage only when enabled and not stalled
	logic advance;
	assign advance = en_i & ~stall_i;

	// Counts up once after reset and then sticks at the limit
	logic [WARM_BITS-1:0] warm_cnt;
	logic warm;

	always_ff @(posedge clk) begin
		if (rst) begin
			warm_cnt <= '0;
		end
		else if (warm) begin
			warm_cnt <= warm_cnt + 1'b1;
		end
	end

	assign warm = (warm_cnt != WARM_BITS'(`FETCH_WARMUP_CYCLES));

	// A stomp only kills groups whose branch number differs from the surviving path
	logic kill;
	assign kill = ~hit_i | (stomp_i & (bno_i != stomp_bno_i)) | nmi_i | flush_i;

	// ======================================================================
	// Slot addresses
	// ======================================================================

	// Each word of the group gets its own address, 4 bytes apart
	// Micro-code runs one word at a time, so every slot repeats the address
	fetch_pkg::pc_t slot_pc [0:`FETCH_LINE_WORDS-1];

	always_comb begin
		for (int i = 0; i < `FETCH_LINE_WORDS; i++) begin
			slot_pc[i] = mc_active_i ? pc_i : pc_i + fetch_pkg::pc_t'(4 * i);
		end
	end

	// Addresses and flags only follow an advance, so a stall holds them
	always_ff @(posedge clk) begin
		if (rst) begin
			pc0_fet_o <= `FETCH_RESET_PC;
			pc1_fet_o <= `FETCH_RESET_PC + 4;
			pc2_fet_o <= `FETCH_RESET_PC + 8;
			pc3_fet_o <= `FETCH_RESET_PC + 12;
			bno_fet_o <= fetch_pkg::bno_t'(1);
			miss_fet_o <= 1'b0;
			flush_fet_o <= 1'b0;
			mc_active_fet_o <= 1'b0;
		end
		else if (advance) begin
			pc0_fet_o <= slot_pc[0];
			pc1_fet_o <= slot_pc[1];
			pc2_fet_o <= slot_pc[2];
			pc3_fet_o <= slot_pc[3];
			bno_fet_o <= bno_i;
			miss_fet_o <= ~hit_i;
			flush_fet_o <= flush_i;
			mc_active_fet_o <= mc_active_i;
		end
	end

	// ======================================================================
	// Line selection
	// ======================================================================

	// Warm-up wins over everything, then injection, then the kill conditions
	// Injection loads even under stall
	always_ff @(posedge clk) begin
		if (rst) begin
			line_fet_o <= NOP_LINE;
		end
		else if (warm) begin
			line_fet_o <= NOP_LINE;
		end
		else if (inject_i) begin
			line_fet_o <= {NOP_HALF, inj_line_i};
		end
		else if (advance) begin
			line_fet_o <= kill ? NOP_LINE : line_i;
		end
	end

endmodule

// File: source/fetch_unit.sv
/*
 * Fetch front end top level: the address sequencer, the
 * instruction cache and the fetch stage register
 */
`timescale 1ns/100ps

module fetch_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   en_i,
	input  logic                   stall_i,
	input  logic                   redirect_i,
	input  fetch_pkg::pc_t         redirect_pc_i,
	input  logic                   mc_active_i,
	input  fetch_pkg::pc_t         mc_adr_i,
	input  logic                   fill_valid_i,
	input  fetch_pkg::pc_t         fill_adr_i,
	input  fetch_pkg::line_t       fill_line_i,
	input  logic                   flush_i,
	input  logic                   nmi_i,
	input  logic                   stomp_i,
	input  fetch_pkg::bno_t        stomp_bno_i,
	input  logic                   inject_i,
	input  fetch_pkg::half_line_t  inj_line_i,
	output fetch_pkg::pc_t         pc0_fet_o,
	output fetch_pkg::pc_t         pc1_fet_o,
	output fetch_pkg::pc_t         pc2_fet_o,
	output fetch_pkg::pc_t         pc3_fet_o,
	output fetch_pkg::bno_t        bno_fet_o,
	output fetch_pkg::line_t       line_fet_o,
	output logic                   miss_fet_o,
	output logic                   flush_fet_o,
	output logic                   mc_active_fet_o
);

	// Current fetch address and its path number
	fetch_pkg::pc_t   pc;
	fetch_pkg::bno_t  bno;

	// Cache result for that address, also steering the sequencer
	logic             hit;
	fetch_pkg::line_t line;

	fetch_pc_sequencer i_fetch_pc_sequencer (
		.clk           (clk),
		.rst           (rst),
		.en_i          (en_i),
		.stall_i       (stall_i),
		.hit_i         (hit),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.mc_active_i   (mc_active_i),
		.mc_adr_i      (mc_adr_i),
		.pc_o          (pc),
		.bno_o         (bno)
	);

	fetch_icache i_fetch_icache (
		.clk          (clk),
		.rst          (rst),
		.pc_i         (pc),
		.fill_valid_i (fill_valid_i),
		.fill_adr_i   (fill_adr_i),
		.fill_line_i  (fill_line_i),
		.hit_o        (hit),
		.line_o       (line)
	);

	fetch_stage i_fetch_stage (
		.clk             (clk),
		.rst             (rst),
		.en_i            (en_i),
		.stall_i         (stall_i),
		.pc_i            (pc),
		.bno_i           (bno),
		.mc_active_i     (mc_active_i),
		.hit_i           (hit),
		.line_i          (line),
		.flush_i         (flush_i),
		.nmi_i           (nmi_i),
		.stomp_i         (stomp_i),
		.stomp_bno_i     (stomp_bno_i),
		.inject_i        (inject_i),
		.inj_line_i      (inj_line_i),
		.pc0_fet_o       (pc0_fet_o),
		.pc1_fet_o       (pc1_fet_o),
		.pc2_fet_o       (pc2_fet_o),
		.pc3_fet_o       (pc3_fet_o),
		.bno_fet_o       (bno_fet_o),
		.line_fet_o      (line_fet_o),
		.miss_fet_o      (miss_fet_o),
		.flush_fet_o     (flush_fet_o),
		.mc_active_fet_o (mc_active_fet_o)
	);

endmodule

// File: bench/fetch_unit_tb.sv
/*
 * Testbench of the fetch front end: clock, reset, per-cycle stimulus
 * and expected outputs read from the trace file, output checks,
 * a warm-up test after a second reset, per-test reporting and a cycle limit
 */
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_unit_tb;

	// ======================================================================
	// Trace layout
	// ======================================================================

	// Tokens per trace row, largest trace and reset length
	localparam int FIELDS = 23;
	localparam int MAX_ROWS = 64;
	localparam int RESET_CYCLES = 16;
	localparam logic [31:0] END_MARK = 32'hff;

	// Stimulus columns
	localparam int F_TEST = 0;
	localparam int F_EN = 1;
	localparam int F_STALL = 2;
	localparam int F_REDIR = 3;
	localparam int F_RPC = 4;
	localparam int F_MC = 5;
	localparam int F_MADR = 6;
	localparam int F_FILL = 7;
	localparam int F_FADR = 8;
	localparam int F_FBASE = 9;
	localparam int F_FLUSH = 10;
	localparam int F_NMI = 11;
	localparam int F_STOMP = 12;
	localparam int F_SBNO = 13;
	localparam int F_INJ = 14;
	localparam int F_IBASE = 15;
	// Expected output columns
	localparam int F_PC0 = 16;
	localparam int F_BNO = 17;
	localparam int F_KIND = 18;
	localparam int F_LBASE = 19;
	localparam int F_MISS = 20;
	localparam int F_FLUSHF = 21;
	localparam int F_MCF = 22;

	// The warm-up test runs after the trace with its own reset
	localparam int WARM_TEST_ID = 7;
	localparam int WARM_TEST_CYCLES = RESET_CYCLES + `FETCH_WARMUP_CYCLES + 2;
	localparam logic [31:0] WARM_BASE = 32'h0c000100;

	// NOP opcode in the top bits with all other fields zero
	localparam fetch_pkg::instr_t NOP_INSTR = {fetch_pkg::OP_NOP, 25'h0};

	logic clk, rst, en_i, stall_i, redirect_i, mc_active_i, fill_valid_i;
	logic flush_i, nmi_i, stomp_i, inject_i;
	logic miss_fet_o, flush_fet_o, mc_active_fet_o;
	fetch_pkg::pc_t redirect_pc_i, mc_adr_i, fill_adr_i;
	fetch_pkg::pc_t pc0_fet_o, pc1_fet_o, pc2_fet_o, pc3_fet_o;
	fetch_pkg::bno_t stomp_bno_i, bno_fet_o;
	fetch_pkg::line_t fill_line_i, line_fet_o;
	fetch_pkg::half_line_t inj_line_i;

	logic [31:0] trace_mem [0:FIELDS*MAX_ROWS-1];
	int errors = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;
	int cycle_limit = MAX_ROWS + RESET_CYCLES + WARM_TEST_CYCLES + 50;

	fetch_unit i_fetch_unit (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ends a run that never reaches the end of the trace
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout after %0d cycles, the trace did not finish", cycle_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] field(input int row, input int col);
		return trace_mem[row * FIELDS + col];
	endfunction

	// Kind 1 is four words counting up from base, kind 2 two NOPs above an injected pair
	function automatic fetch_pkg::line_t make_line(input logic [31:0] kind,
			input logic [31:0] base);
		fetch_pkg::line_t line;
		case (kind)
			32'd1: line = {base + 32'd3, base + 32'd2, base + 32'd1, base};
			32'd2: line = {NOP_INSTR, NOP_INSTR, base + 32'd1, base};
			default: line = {4{NOP_INSTR}};
		endcase
		return line;
	endfunction

	task automatic apply_row(input int row);
		en_i <= field(row, F_EN) != 0;
		stall_i <= field(row, F_STALL) != 0;
		redirect_i <= field(row, F_REDIR) != 0;
		redirect_pc_i <= field(row, F_RPC);
		mc_active_i <= field(row, F_MC) != 0;
		mc_adr_i <= field(row, F_MADR);
		fill_valid_i <= field(row, F_FILL) != 0;
		fill_adr_i <= field(row, F_FADR);
		fill_line_i <= make_line(32'd1, field(row, F_FBASE));
		flush_i <= field(row, F_FLUSH) != 0;
		nmi_i <= field(row, F_NMI) != 0;
		stomp_i <= field(row, F_STOMP) != 0;
		stomp_bno_i <= fetch_pkg::bno_t'(field(row, F_SBNO));
		inject_i <= field(row, F_INJ) != 0;
		inj_line_i <= {field(row, F_IBASE) + 32'd1, field(row, F_IBASE)};
	endtask

	task automatic idle_inputs();
		{en_i, stall_i, redirect_i, mc_active_i, fill_valid_i} <= '0;
		{flush_i, nmi_i, stomp_i, inject_i} <= '0;
		{redirect_pc_i, mc_adr_i, fill_adr_i, fill_line_i} <= '0;
		stomp_bno_i <= '0;
		inj_line_i <= '0;
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		$display("FAILED at time %0t: %s expected %0h, got %0h", $time, name,
			expected, actual);
		errors++;
		test_errors++;
	endtask

	// Slots sit step bytes apart from pc0
	task automatic compare_outputs(input fetch_pkg::pc_t pc0, input fetch_pkg::pc_t step,
			input fetch_pkg::bno_t bno, input fetch_pkg::line_t line, input logic miss,
			input logic flush, input logic mc);
		if (pc0_fet_o !== pc0) begin
			report_mismatch("pc0_fet_o", pc0, pc0_fet_o);
		end
		if (pc1_fet_o !== pc0 + step) begin
			report_mismatch("pc1_fet_o", pc0 + step, pc1_fet_o);
		end
		if (pc2_fet_o !== pc0 + 2 * step) begin
			report_mismatch("pc2_fet_o", pc0 + 2 * step, pc2_fet_o);
		end
		if (pc3_fet_o !== pc0 + 3 * step) begin
			report_mismatch("pc3_fet_o", pc0 + 3 * step, pc3_fet_o);
		end
		if (bno_fet_o !== bno) begin
			report_mismatch("bno_fet_o", bno, bno_fet_o);
		end
		if (line_fet_o !== line) begin
			report_mismatch("line_fet_o", line, line_fet_o);
		end
		if (miss_fet_o !== miss) begin
			report_mismatch("miss_fet_o", miss, miss_fet_o);
		end
		if (flush_fet_o !== flush) begin
			report_mismatch("flush_fet_o", flush, flush_fet_o);
		end
		if (mc_active_fet_o !== mc) begin
			report_mismatch("mc_active_fet_o", mc, mc_active_fet_o);
		end
	endtask

	// Slots sit 4 bytes apart, or all on one address under the micro-machine
	task automatic check_row(input int row);
		fetch_pkg::pc_t step;
		step = (field(row, F_MCF) != 0) ? 32'd0 : 32'd4;
		compare_outputs(field(row, F_PC0), step, fetch_pkg::bno_t'(field(row, F_BNO)),
			make_line(field(row, F_KIND), field(row, F_LBASE)), field(row, F_MISS) != 0,
			field(row, F_FLUSHF) != 0, field(row, F_MCF) != 0);
	endtask

	task automatic finish_test(input logic [31:0] test);
		if (test_errors == 0) begin
			$display("Test %0d done: all checks matched", test);
			tests_passed++;
		end
		else begin
			$display("Test %0d done: %0d mismatches", test, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	// A second reset empties the cache, then the reset line is filled at once
	// The micro-machine parks the fetch address on that line so it hits from the second cycle
	// Only the warm-up count keeps the line NOP until it runs out
	task automatic run_warmup_test();
		fetch_pkg::line_t nop_line;
		fetch_pkg::line_t filled;
		nop_line = make_line(32'd0, 32'd0);
		filled = make_line(32'd1, WARM_BASE);
		@(posedge clk);
		rst <= 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		// Reset state of the stage, seen before the last reset edge
		@(negedge clk);
		compare_outputs(`FETCH_RESET_PC, 32'd4, fetch_pkg::bno_t'(1), nop_line,
			1'b0, 1'b0, 1'b0);
		@(posedge clk);
		rst <= 1'b0;
		en_i <= 1'b1;
		mc_active_i <= 1'b1;
		mc_adr_i <= `FETCH_RESET_PC;
		fill_valid_i <= 1'b1;
		fill_adr_i <= `FETCH_RESET_PC;
		fill_line_i <= filled;
		for (int k = 0; k <= `FETCH_WARMUP_CYCLES; k++) begin
			@(posedge clk);
			fill_valid_i <= 1'b0;
			@(negedge clk);
			compare_outputs(`FETCH_RESET_PC, 32'd0, fetch_pkg::bno_t'(1),
				(k < `FETCH_WARMUP_CYCLES) ? nop_line : filled, k == 0, 1'b0, 1'b1);
		end
		finish_test(WARM_TEST_ID);
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		int rows;
		rst <= 1'b1;
		idle_inputs();
		$readmemh("bench/fetch_unit_trace.txt", trace_mem);
		rows = 0;
		while (rows < MAX_ROWS && field(rows, F_TEST) != END_MARK) begin
			rows++;
		end
		if (rows == 0 || rows == MAX_ROWS) begin
			$display("Trace file is missing, empty or has no end marker");
			errors++;
		end
		else begin
			cycle_limit = rows + RESET_CYCLES + WARM_TEST_CYCLES + 50;
			repeat (RESET_CYCLES) @(posedge clk);
			rst <= 1'b0;
			apply_row(0);
			// Row r is sampled at the next edge and checked at the falling edge after it
			for (int row = 0; row < rows; row++) begin
				@(posedge clk);
				if (row + 1 < rows) begin
					apply_row(row + 1);
				end
				else begin
					idle_inputs();
				end
				@(negedge clk);
				check_row(row);
				if (row + 1 == rows || field(row + 1, F_TEST) != field(row, F_TEST)) begin
					finish_test(field(row, F_TEST));
				end
			end
			run_warmup_test();
		end
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
			tests_passed + tests_failed, tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("** PASS **");
		end
		else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: fetch_unit.f
+incdir+source
source/fetch_pkg.sv
source/fetch_pc_sequencer.sv
source/fetch_icache.sv
source/fetch_stage.sv
source/fetch_unit.sv
bench/fetch_unit_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_LINE ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q -F -x '$(PASS_LINE)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fetch_unit_trace.txt
// test en stall redir rpc mc madr fill fadr fbase flush nmi stomp sbno inj ibase
// then expected: pc0 bno kind lbase miss flush mc (kind 0 NOP, 1 line from base, 2 inject)
// All hex, one row per cycle after reset; ff on its own ends the trace
1 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   100 01 0 00000000 1 0 0
1 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   100 01 0 00000000 1 0 0
1 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   100 01 0 00000000 1 0 0
1 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   100 01 0 00000000 1 0 0
2 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   100 01 0 00000000 1 0 0
2 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   100 01 0 00000000 1 0 0
2 1 0 0 000 0 000 1 100 04000100 0 0 0 00 0 00000000   100 01 0 00000000 1 0 0
2 1 0 0 000 0 000 1 110 04000110 0 0 0 00 0 00000000   100 01 1 04000100 0 0 0
2 1 0 0 000 0 000 1 120 04000120 0 0 0 00 0 00000000   110 01 1 04000110 0 0 0
2 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   120 01 1 04000120 0 0 0
3 1 0 1 100 0 000 0 000 00000000 0 0 0 00 0 00000000   130 01 0 00000000 1 0 0
3 1 0 0 000 0 000 0 000 00000000 0 0 1 02 0 00000000   100 02 1 04000100 0 0 0
3 1 0 0 000 0 000 0 000 00000000 0 0 1 01 0 00000000   110 02 0 00000000 0 0 0
3 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   120 02 1 04000120 0 0 0
3 1 0 1 110 0 000 0 000 00000000 0 0 0 00 0 00000000   130 02 0 00000000 1 0 0
4 1 0 0 000 0 000 0 000 00000000 1 0 0 00 0 00000000   110 03 0 00000000 0 1 0
4 1 0 0 000 0 000 0 000 00000000 0 1 0 00 0 00000000   120 03 0 00000000 0 0 0
4 1 0 1 100 0 000 0 000 00000000 0 0 0 00 0 00000000   130 03 0 00000000 1 0 0
4 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   100 04 1 04000100 0 0 0
5 1 0 0 000 1 120 0 000 00000000 0 0 0 00 0 00000000   120 04 1 04000120 0 0 1
5 1 0 0 000 1 100 0 000 00000000 0 0 0 00 0 00000000   100 04 1 04000100 0 0 1
5 1 0 0 000 1 200 0 000 00000000 0 0 0 00 0 00000000   200 04 0 00000000 1 0 1
5 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   110 04 1 04000110 0 0 0
6 1 1 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   110 04 1 04000110 0 0 0
6 1 1 0 000 0 000 0 000 00000000 0 0 0 00 1 08000000   110 04 2 08000000 0 0 0
6 1 1 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   110 04 2 08000000 0 0 0
6 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   120 04 1 04000120 0 0 0
6 1 0 0 000 0 000 0 000 00000000 0 0 0 00 0 00000000   130 04 0 00000000 1 0 0
ff
